//--- filelist.f
+incdir+include
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mul.sv
verilog/ex_div.sv
verilog/ex_mem_reg.sv
verilog/ex_stage.sv
test/tb_ex_stage.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_ex_stage
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/ex_ref.svh
// reference functions for the expected execute result and branch decision
`ifndef EX_REF_SVH
`define EX_REF_SVH

import ex_pkg::*;

function automatic logic [XLEN-1:0] ref_result(input logic [ALU_OP_W-1:0] op,
	input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
	logic signed [2*XLEN-1:0] ss;
	logic signed [2*XLEN-1:0] su;
	logic [2*XLEN-1:0]        uu;
	logic signed [XLEN-1:0]   sq;                         // signed quotient
	logic signed [XLEN-1:0]   sr;                         // signed remainder
	logic                     ovf;
	ss  = $signed(a) * $signed(b);
	su  = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{1'b0}}, b});
	uu  = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
	ovf = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1); // min / -1
	sq  = '0;
	sr  = '0;
	if (b != '0 && !ovf)
	begin
		sq = $signed(a) / $signed(b);
		sr = $signed(a) % $signed(b);
	end
	case (op)
		OP_ADD:    return a + b;
		OP_SUB:    return a - b;
		OP_SLT:    return ($signed(a) < $signed(b)) ? 1 : 0;
		OP_SLTU:   return (a < b) ? 1 : 0;
		OP_AND:    return a & b;
		OP_OR:     return a | b;
		OP_XOR:    return a ^ b;
		OP_SLL:    return a << b[SHAMT_W-1:0];
		OP_SRL:    return a >> b[SHAMT_W-1:0];
		OP_SRA:    return $signed(a) >>> b[SHAMT_W-1:0];
		OP_MUL:    return uu[XLEN-1:0];
		OP_MULH:   return ss[2*XLEN-1:XLEN];
		OP_MULHSU: return su[2*XLEN-1:XLEN];
		OP_MULHU:  return uu[2*XLEN-1:XLEN];
		OP_DIV:    return (b == 0) ? '1 : (ovf ? a : sq);
		OP_DIVU:   return (b == 0) ? '1 : a / b;
		OP_REM:    return (b == 0) ? a : (ovf ? '0 : sr);
		OP_REMU:   return (b == 0) ? a : a % b;
		OP_PASS:   return b;
		default:   return '0;
	endcase
endfunction

// returns {branch, taken}
function automatic logic [1:0] ref_branch(input logic [BR_OP_W-1:0] br,
	input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
	case (br)
		BR_EQ:   return {1'b1, a == b};
		BR_NE:   return {1'b1, a != b};
		BR_LT:   return {1'b1, $signed(a) < $signed(b)};
		BR_GE:   return {1'b1, $signed(a) >= $signed(b)};
		BR_LTU:  return {1'b1, a < b};
		BR_GEU:  return {1'b1, a >= b};
		default: return 2'b00;
	endcase
endfunction

`endif

//--- test/tb_ex_stage.sv
`timescale 1ns/1ps
// testbench for the execute stage with stimulus, result compare, watchdog and report
module tb_ex_stage
	import ex_pkg::*;
();
	`include "ex_ref.svh"

	localparam int CLK_PERIOD      = 10;
	localparam int NUM_OPS         = 172;           // instructions over all six tests
	localparam int WATCHDOG_CYCLES = NUM_OPS * 50;
	localparam int BUS_W           = 3*XLEN + RD_W + MEM_SIZE_W + 4;
	localparam int EXP_NONE        = 0;
	localparam int EXP_INSTR       = 1;             // accepted op lands in MEM
	localparam int EXP_BUBBLE      = 2;
	localparam int EXP_HOLD        = 3;             // back-pressure, MEM frozen

	logic                  cpu_clk = 1'b0;
	logic                  cpu_rstn;
	logic                  dec_valid_i;
	logic                  ex_ready_o;
	logic [XLEN-1:0]       src1_i;
	logic [XLEN-1:0]       src2_i;
	logic [XLEN-1:0]       store_data_i;
	logic [ALU_OP_W-1:0]   alu_op_i;
	logic [BR_OP_W-1:0]    br_op_i;
	logic [RD_W-1:0]       rd_i;
	logic                  load_i;
	logic                  store_i;
	logic                  mem_unsigned_i;
	logic [MEM_SIZE_W-1:0] mem_size_i;
	logic [XLEN-1:0]       alu_result_ex_o;
	logic                  branch_o;
	logic                  branch_taken_o;
	logic                  mem_ready_i;
	logic                  ex_valid_o;
	logic [XLEN-1:0]       alu_result_mem_o;
	logic [XLEN-1:0]       store_data_mem_o;
	logic [XLEN-1:0]       mem_addr_mem_o;
	logic [RD_W-1:0]       rd_mem_o;
	logic                  load_mem_o;
	logic                  store_mem_o;
	logic                  mem_unsigned_mem_o;
	logic [MEM_SIZE_W-1:0] mem_size_mem_o;

	int seed = 32'hab18;
	int errors = 0;
	int checks = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int test_base = 0;                              // errors before the running test
	int expect_kind = EXP_NONE;

	logic [XLEN-1:0]       exp_result;
	logic [XLEN-1:0]       exp_store_data;
	logic [XLEN-1:0]       exp_addr;
	logic [RD_W-1:0]       exp_rd;
	logic                  exp_load;
	logic                  exp_store;
	logic                  exp_uns;
	logic [MEM_SIZE_W-1:0] exp_size;
	logic [1:0]            exp_br;                  // {branch, taken}
	logic [BUS_W-1:0]      snap;                    // MEM outputs before a stall edge

	logic [ALU_OP_W-1:0]   int_ops [11] = '{OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR,
		OP_XOR, OP_SLL, OP_SRL, OP_SRA, OP_PASS};
	logic [ALU_OP_W-1:0]   mul_ops [4] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
	logic [ALU_OP_W-1:0]   div_ops [4] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
	logic [BR_OP_W-1:0]    br_ops [6] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
	logic [MEM_SIZE_W-1:0] sizes [3] = '{SIZE_B, SIZE_H, SIZE_W};
	logic [XLEN-1:0]       corners [3] = '{32'h0, 32'hffff_ffff, 32'h8000_0000};
	logic [XLEN-1:0]       br_a [6] = '{32'h1234, 32'd3, 32'd9, 32'hffff_fffc, 32'd5,
		32'hffff_ffff};
	logic [XLEN-1:0]       br_b [6] = '{32'h1234, 32'd9, 32'd3, 32'd5, 32'hffff_fffc,
		32'hffff_ffff};

	ex_stage u_dut (.*);

	always #(CLK_PERIOD/2) cpu_clk = ~cpu_clk;

	function automatic logic [BUS_W-1:0] mem_bus();
		return {ex_valid_o, alu_result_mem_o, store_data_mem_o, mem_addr_mem_o, rd_mem_o,
			load_mem_o, store_mem_o, mem_unsigned_mem_o, mem_size_mem_o};
	endfunction

	task automatic check_value(input string name, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Mismatch at %0d ns: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// drive one instruction, optionally with MEM stalled first, and wait until taken
	task automatic send(input logic [ALU_OP_W-1:0] op, input logic [BR_OP_W-1:0] br,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [RD_W-1:0] rd,
		input logic ld, input logic st, input logic [MEM_SIZE_W-1:0] size, input logic uns,
		input logic [XLEN-1:0] sd, input int stall);
		dec_valid_i    <= 1'b1;
		alu_op_i       <= op;
		br_op_i        <= br;
		src1_i         <= a;
		src2_i         <= b;
		rd_i           <= rd;
		load_i         <= ld;
		store_i        <= st;
		mem_size_i     <= size;
		mem_unsigned_i <= uns;
		store_data_i   <= sd;
		if (stall > 0)
		begin
			mem_ready_i <= 1'b0;                       // MEM busy while the op waits
			repeat (stall) @(posedge cpu_clk);
			mem_ready_i <= 1'b1;
		end
		@(posedge cpu_clk);
		while (!ex_ready_o)                            // divides hold ready low
			@(posedge cpu_clk);
		dec_valid_i <= 1'b0;
	endtask

	task automatic send_alu(input logic [ALU_OP_W-1:0] op, input logic [XLEN-1:0] a,
		input logic [XLEN-1:0] b);
		logic [RD_W-1:0] rd;
		rd = RD_W'({$random(seed)} % 32);              // never the no-write value
		send(op, BR_NONE, a, b, rd, 1'b0, 1'b0, SIZE_W, 1'b0, '0, 0);
	endtask

	task automatic end_test(input int num, input string name);
		dec_valid_i <= 1'b0;
		repeat (3) @(posedge cpu_clk);                 // last result plus bubbles reach MEM
		if (errors == test_base)
		begin
			tests_passed++;
			$display("test %0d %s: pass", num, name);
		end
		else
		begin
			tests_failed++;
			$display("test %0d %s: fail with %0d errors", num, name, errors - test_base);
		end
		test_base = errors;
	endtask

	// compare MEM outputs one edge after what the previous edge loaded
	always @(posedge cpu_clk)
	begin
		if (expect_kind == EXP_INSTR)
		begin
			check_value("ex_valid_o", 1, XLEN'(ex_valid_o));
			check_value("alu_result_mem_o", exp_result, alu_result_mem_o);
			check_value("store_data_mem_o", exp_store_data, store_data_mem_o);
			check_value("mem_addr_mem_o", exp_addr, mem_addr_mem_o);
			check_value("rd_mem_o", XLEN'(exp_rd), XLEN'(rd_mem_o));
			check_value("load_mem_o", XLEN'(exp_load), XLEN'(load_mem_o));
			check_value("store_mem_o", XLEN'(exp_store), XLEN'(store_mem_o));
			check_value("mem_unsigned_mem_o", XLEN'(exp_uns), XLEN'(mem_unsigned_mem_o));
			check_value("mem_size_mem_o", XLEN'(exp_size), XLEN'(mem_size_mem_o));
		end
		else if (expect_kind == EXP_BUBBLE)
		begin
			check_value("ex_valid_o", 0, XLEN'(ex_valid_o));
			check_value("rd_mem_o", XLEN'(RD_NONE), XLEN'(rd_mem_o));
			check_value("load_mem_o", 0, XLEN'(load_mem_o));
			check_value("store_mem_o", 0, XLEN'(store_mem_o));
			check_value("alu_result_mem_o", 0, alu_result_mem_o);
			check_value("store_data_mem_o", 0, store_data_mem_o);
			check_value("mem_addr_mem_o", 0, mem_addr_mem_o);
			check_value("mem_unsigned_mem_o", 0, XLEN'(mem_unsigned_mem_o));
			check_value("mem_size_mem_o", 0, XLEN'(mem_size_mem_o));
		end
		else if (expect_kind == EXP_HOLD)
		begin
			checks++;
			if (mem_bus() !== snap)
			begin
				errors++;
				$display("Mismatch at %0d ns: mem outputs expected %h got %h", $time, snap,
					mem_bus());
			end
		end
		if (!cpu_rstn)
			expect_kind = EXP_NONE;
		else if (!mem_ready_i)
		begin
			expect_kind = EXP_HOLD;                    // nothing may enter MEM
			snap        = mem_bus();
			checks++;
			if (ex_ready_o)
			begin
				errors++;
				$display("ex_ready_o is high at %0d ns while mem_ready_i is low", $time);
			end
		end
		else if (dec_valid_i && ex_ready_o)
		begin
			expect_kind    = EXP_INSTR;
			exp_result     = ref_result(alu_op_i, src1_i, src2_i);
			exp_store_data = store_data_i;
			exp_addr       = (load_i || store_i) ? exp_result : '0; // address only for memory ops
			exp_rd         = rd_i;
			exp_load       = load_i;
			exp_store      = store_i;
			exp_uns        = mem_unsigned_i;
			exp_size       = mem_size_i;
			exp_br         = ref_branch(br_op_i, src1_i, src2_i);
			check_value("alu_result_ex_o", exp_result, alu_result_ex_o);
			check_value("branch_o", XLEN'(exp_br[1]), XLEN'(branch_o));
			check_value("branch_taken_o", XLEN'(exp_br[0]), XLEN'(branch_taken_o));
		end
		else
			expect_kind = EXP_BUBBLE;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		logic [XLEN-1:0] a;
		int              k;
		cpu_rstn       = 1'b0;
		dec_valid_i    = 1'b0;
		mem_ready_i    = 1'b1;
		src1_i         = '0;
		src2_i         = '0;
		store_data_i   = '0;
		alu_op_i       = OP_ADD;
		br_op_i        = BR_NONE;
		rd_i           = RD_NONE;
		load_i         = 1'b0;
		store_i        = 1'b0;
		mem_unsigned_i = 1'b0;
		mem_size_i     = SIZE_B;
		repeat (10) @(posedge cpu_clk);
		cpu_rstn <= 1'b1;
		@(posedge cpu_clk);
		check_value("ex_valid_o", 0, XLEN'(ex_valid_o));    // reset state of MEM
		check_value("load_mem_o", 0, XLEN'(load_mem_o));
		check_value("store_mem_o", 0, XLEN'(store_mem_o));
		check_value("rd_mem_o", XLEN'(RD_NONE), XLEN'(rd_mem_o));
		for (int i = 0; i < 11; i++)
			for (int r = 0; r < 4; r++)
				send_alu(int_ops[i], $random(seed), $random(seed));
		end_test(1, "integer ops");

		for (int i = 0; i < 4; i++)
		begin
			for (int r = 0; r < 4; r++)
				send_alu(mul_ops[i], $random(seed), $random(seed));
			for (int j = 0; j < 3; j++)
				for (int m = 0; m < 3; m++)
					send_alu(mul_ops[i], corners[j], corners[m]);
		end
		end_test(2, "multiply");

		for (int i = 0; i < 4; i++)
		begin
			send_alu(div_ops[i], $random(seed), $random(seed));
			send_alu(div_ops[i], $random(seed), $random(seed) >>> 24);  // small divisor
			send_alu(div_ops[i], $random(seed), $random(seed));
			send_alu(div_ops[i], $random(seed), '0);                      // divide by zero
			send_alu(div_ops[i], 32'h8000_0000, 32'hffff_ffff);           // overflow
		end
		end_test(3, "divide");

		for (int i = 0; i < 6; i++)
			for (int p = 0; p < 6; p++)
				send(OP_SUB, br_ops[i], br_a[p], br_b[p], RD_W'(1), 1'b0, 1'b0, SIZE_W, 1'b0,
					'0, 0);
		end_test(4, "branches");

		for (int i = 0; i < 3; i++)
		begin
			a = $random(seed);
			send(OP_ADD, BR_NONE, a, 32'(i * 4), RD_W'(i + 5), 1'b1, 1'b0, sizes[i], a[0],
				'0, 0);
			send(OP_ADD, BR_NONE, a, 32'h40, RD_NONE, 1'b0, 1'b1, sizes[i], 1'b0,
				$random(seed), 0);
		end
		dec_valid_i <= 1'b0;                             // one idle cycle, bubble in MEM
		@(posedge cpu_clk);
		send(OP_XOR, BR_NONE, $random(seed), $random(seed), RD_W'(9), 1'b0, 1'b0, SIZE_H,
			1'b1, $random(seed), 0);
		send(OP_PASS, BR_NONE, '0, 32'h1234_5000, RD_W'(10), 1'b0, 1'b0, SIZE_W, 1'b0,
			$random(seed), 0);
		end_test(5, "memory fields");

		for (int i = 0; i < 12; i++)
		begin
			k = 1 + ({$random(seed)} % 5);                // stall length in cycles
			send(int_ops[{$random(seed)} % 11], BR_NONE, $random(seed), $random(seed),
				RD_W'(i + 1), 1'b0, 1'b0, SIZE_W, 1'b0, $random(seed), k);
		end
		end_test(6, "back-pressure");

		$display("%0d tests passed, %0d tests failed, %0d checks, %0d errors", tests_passed,
			tests_failed, checks, errors);
		if (tests_failed == 0 && errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end
endmodule

//--- verilog/ex_stage.sv
`timescale 1ns/1ps
// execute stage top with datapath, multiplier, divider, EX/MEM register and handshake
module ex_stage
	import ex_pkg::*;
(
	input  logic                  cpu_clk,
	input  logic                  cpu_rstn,
	input  logic                  dec_valid_i,        // decode has an instruction
	output logic                  ex_ready_o,         // stage can accept
	input  logic [XLEN-1:0]       src1_i,
	input  logic [XLEN-1:0]       src2_i,
	input  logic [XLEN-1:0]       store_data_i,
	input  logic [ALU_OP_W-1:0]   alu_op_i,
	input  logic [BR_OP_W-1:0]    br_op_i,
	input  logic [RD_W-1:0]       rd_i,
	input  logic                  load_i,
	input  logic                  store_i,
	input  logic                  mem_unsigned_i,
	input  logic [MEM_SIZE_W-1:0] mem_size_i,
	output logic [XLEN-1:0]       alu_result_ex_o,    // forwarding path to decode
	output logic                  branch_o,
	output logic                  branch_taken_o,
	input  logic                  mem_ready_i,        // memory stage back-pressure
	output logic                  ex_valid_o,
	output logic [XLEN-1:0]       alu_result_mem_o,
	output logic [XLEN-1:0]       store_data_mem_o,
	output logic [XLEN-1:0]       mem_addr_mem_o,
	output logic [RD_W-1:0]       rd_mem_o,
	output logic                  load_mem_o,
	output logic                  store_mem_o,
	output logic                  mem_unsigned_mem_o,
	output logic [MEM_SIZE_W-1:0] mem_size_mem_o
);
	logic            is_div;       // divide-class op in EX
	logic            div_req;
	logic            div_done;
	logic            fire;         // instruction accepted this edge
	logic [XLEN-1:0] mul_result;
	logic [XLEN-1:0] div_result;

	assign is_div = (alu_op_i == OP_DIV) || (alu_op_i == OP_DIVU) ||
		(alu_op_i == OP_REM) || (alu_op_i == OP_REMU);
	assign div_req = dec_valid_i && is_div;
	assign ex_ready_o = mem_ready_i && !(div_req && !div_done); // stall while divider busy
	assign fire = dec_valid_i && ex_ready_o;

	ex_alu u_alu (
		.src1_i         (src1_i),
		.src2_i         (src2_i),
		.alu_op_i       (alu_op_i),
		.br_op_i        (br_op_i),
		.mul_result_i   (mul_result),
		.div_result_i   (div_result),
		.result_o       (alu_result_ex_o),
		.branch_o       (branch_o),
		.branch_taken_o (branch_taken_o)
	);

	ex_mul u_mul (
		.src1_i   (src1_i),
		.src2_i   (src2_i),
		.alu_op_i (alu_op_i),
		.result_o (mul_result)
	);

	ex_div u_div (
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.req_i    (div_req),
		.accept_i (fire),
		.alu_op_i (alu_op_i),
		.src1_i   (src1_i),
		.src2_i   (src2_i),
		.done_o   (div_done),
		.result_o (div_result)
	);

	ex_mem_reg u_mem_reg (
		.cpu_clk            (cpu_clk),
		.cpu_rstn           (cpu_rstn),
		.mem_ready_i        (mem_ready_i),
		.fire_i             (fire),
		.result_i           (alu_result_ex_o),
		.rd_i               (rd_i),
		.load_i             (load_i),
		.store_i            (store_i),
		.mem_size_i         (mem_size_i),
		.mem_unsigned_i     (mem_unsigned_i),
		.store_data_i       (store_data_i),
		.ex_valid_o         (ex_valid_o),
		.alu_result_mem_o   (alu_result_mem_o),
		.store_data_mem_o   (store_data_mem_o),
		.mem_addr_mem_o     (mem_addr_mem_o),
		.rd_mem_o           (rd_mem_o),
		.load_mem_o         (load_mem_o),
		.store_mem_o        (store_mem_o),
		.mem_unsigned_mem_o (mem_unsigned_mem_o),
		.mem_size_mem_o     (mem_size_mem_o)
	);
endmodule

//--- verilog/ex_mem_reg.sv
`timescale 1ns/1ps
// EX/MEM pipeline register with bubble insert, back-pressure hold and memory address
module ex_mem_reg
	import ex_pkg::*;
(
	input  logic                  cpu_clk,
	input  logic                  cpu_rstn,
	input  logic                  mem_ready_i,
	input  logic                  fire_i,          // instruction accepted
	input  logic [XLEN-1:0]       result_i,
	input  logic [RD_W-1:0]       rd_i,
	input  logic                  load_i,
	input  logic                  store_i,
	input  logic [MEM_SIZE_W-1:0] mem_size_i,
	input  logic                  mem_unsigned_i,
	input  logic [XLEN-1:0]       store_data_i,
	output logic                  ex_valid_o,
	output logic [XLEN-1:0]       alu_result_mem_o,
	output logic [XLEN-1:0]       store_data_mem_o,
	output logic [XLEN-1:0]       mem_addr_mem_o,
	output logic [RD_W-1:0]       rd_mem_o,
	output logic                  load_mem_o,
	output logic                  store_mem_o,
	output logic                  mem_unsigned_mem_o,
	output logic [MEM_SIZE_W-1:0] mem_size_mem_o
);
	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			ex_valid_o         <= 1'b0;
			alu_result_mem_o   <= '0;
			store_data_mem_o   <= '0;
			rd_mem_o           <= RD_NONE;
			load_mem_o         <= 1'b0;
			store_mem_o        <= 1'b0;
			mem_unsigned_mem_o <= 1'b0;
			mem_size_mem_o     <= SIZE_B;
		end
		else if (fire_i)
		begin
			ex_valid_o         <= 1'b1;
			alu_result_mem_o   <= result_i;
			store_data_mem_o   <= store_data_i;
			rd_mem_o           <= rd_i;
			load_mem_o         <= load_i;
			store_mem_o        <= store_i;
			mem_unsigned_mem_o <= mem_unsigned_i;
			mem_size_mem_o     <= mem_size_i;
		end
		else if (mem_ready_i)
		begin
			ex_valid_o         <= 1'b0;     // bubble, nothing accepted
			alu_result_mem_o   <= '0;
			store_data_mem_o   <= '0;
			rd_mem_o           <= RD_NONE;
			load_mem_o         <= 1'b0;
			store_mem_o        <= 1'b0;
			mem_unsigned_mem_o <= 1'b0;
			mem_size_mem_o     <= SIZE_B;
		end
	end

	assign mem_addr_mem_o = (load_mem_o || store_mem_o) ? alu_result_mem_o : '0;

	// decode never issues a combined load and store
	assert property (@(posedge cpu_clk) disable iff (!cpu_rstn) !(load_mem_o && store_mem_o))
		else $error("load and store both set at MEM");

	// an instruction with no effect downstream never shows as valid
	assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		(rd_mem_o == RD_NONE && !load_mem_o && !store_mem_o) |-> !ex_valid_o)
		else $error("valid MEM slot with no rd and no memory access");
endmodule

//--- verilog/ex_div.sv
`timescale 1ns/1ps
// iterative radix-2 divider for div, divu, rem and remu with request/accept control
module ex_div
	import ex_pkg::*;
(
	input  logic                cpu_clk,
	input  logic                cpu_rstn,
	input  logic                req_i,      // divide op waiting in EX
	input  logic                accept_i,   // EX handed the result on
	input  logic [ALU_OP_W-1:0] alu_op_i,
	input  logic [XLEN-1:0]     src1_i,     // dividend
	input  logic [XLEN-1:0]     src2_i,     // divisor
	output logic                done_o,
	output logic [XLEN-1:0]     result_o
);
	logic [DIV_ST_W-1:0]  state_q;
	logic [DIV_CNT_W-1:0] cnt_q;       // shift steps taken
	logic [XLEN-1:0]      rem_q;       // partial remainder
	logic [XLEN-1:0]      quo_q;       // dividend shifting out, quotient shifting in
	logic [XLEN-1:0]      dvsr_q;      // divisor magnitude
	logic [XLEN-1:0]      result_q;
	logic                 neg_quo_q;
	logic                 neg_rem_q;
	logic                 want_rem_q;
	logic                 is_signed;
	logic                 is_rem;
	logic                 sign1;
	logic                 sign2;
	logic                 last_step;
	logic [XLEN:0]        rem_shift;
	logic [XLEN:0]        rem_diff;

	assign is_signed = (alu_op_i == OP_DIV) || (alu_op_i == OP_REM);
	assign is_rem    = (alu_op_i == OP_REM) || (alu_op_i == OP_REMU);
	assign sign1     = is_signed && src1_i[XLEN-1];
	assign sign2     = is_signed && src2_i[XLEN-1];
	assign last_step = (cnt_q == DIV_CNT_W'(XLEN));  // sign-fix step
	assign rem_shift = {rem_q, quo_q[XLEN-1]};
	assign rem_diff  = rem_shift - {1'b0, dvsr_q};   // msb set means no subtract

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			state_q <= DIV_IDLE;
			cnt_q   <= '0;
		end
		else
		begin
			case (state_q)
				DIV_IDLE:
				begin
					cnt_q <= '0;
					if (req_i)
						state_q <= DIV_RUN;   // setup happens on this edge
				end
				DIV_RUN:
				begin
					cnt_q <= cnt_q + 1'b1;
					if (!req_i)
						state_q <= DIV_IDLE;  // decode withdrew, abandon
					else if (last_step)
						state_q <= DIV_DONE;
				end
				DIV_DONE:
				begin
					if (accept_i || !req_i)
						state_q <= DIV_IDLE;
				end
				default: state_q <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge cpu_clk)
	begin
		if ((state_q == DIV_IDLE) && req_i)
		begin
			quo_q      <= sign1 ? -src1_i : src1_i;
			dvsr_q     <= sign2 ? -src2_i : src2_i;
			rem_q      <= '0;
			neg_quo_q  <= (sign1 ^ sign2) && (|src2_i); // x/0 keeps all ones
			neg_rem_q  <= sign1;                        // remainder follows dividend
			want_rem_q <= is_rem;
		end
		else if ((state_q == DIV_RUN) && !last_step)
		begin
			if (!rem_diff[XLEN])
			begin
				rem_q <= rem_diff[XLEN-1:0];
				quo_q <= {quo_q[XLEN-2:0], 1'b1};
			end
			else
			begin
				rem_q <= rem_shift[XLEN-1:0];
				quo_q <= {quo_q[XLEN-2:0], 1'b0};
			end
		end
		else if (state_q == DIV_RUN)
		begin
			if (want_rem_q)
				result_q <= neg_rem_q ? -rem_q : rem_q;
			else
				result_q <= neg_quo_q ? -quo_q : quo_q; // min/-1 falls out as min
		end
	end

	assign done_o   = (state_q == DIV_DONE);
	assign result_o = result_q;

	// decode must hold the divide until the stage takes the result
	assert property (@(posedge cpu_clk) disable iff (!cpu_rstn) done_o |-> req_i)
		else $error("divider done with no request pending");
endmodule

//--- verilog/ex_mul.sv
`timescale 1ns/1ps
// single-cycle multiplier for mul, mulh, mulhsu and mulhu
module ex_mul
	import ex_pkg::*;
(
	input  logic [XLEN-1:0]     src1_i,
	input  logic [XLEN-1:0]     src2_i,
	input  logic [ALU_OP_W-1:0] alu_op_i,
	output logic [XLEN-1:0]     result_o
);
	logic              s1_signed;      // src1 taken as signed
	logic              s2_signed;
	logic              neg1;
	logic              neg2;
	logic [XLEN-1:0]   mag1;
	logic [XLEN-1:0]   mag2;
	logic [2*XLEN-1:0] prod_u;         // magnitude product
	logic [2*XLEN-1:0] prod;

	assign s1_signed = (alu_op_i == OP_MUL) || (alu_op_i == OP_MULH) ||
		(alu_op_i == OP_MULHSU);
	assign s2_signed = (alu_op_i == OP_MUL) || (alu_op_i == OP_MULH);

	assign neg1 = s1_signed && src1_i[XLEN-1];
	assign neg2 = s2_signed && src2_i[XLEN-1];
	assign mag1 = neg1 ? -src1_i : src1_i;     // most negative maps to 2^31, still fits
	assign mag2 = neg2 ? -src2_i : src2_i;

	assign prod_u = {{XLEN{1'b0}}, mag1} * {{XLEN{1'b0}}, mag2};
	assign prod   = (neg1 ^ neg2) ? -prod_u : prod_u; // zero stays zero

	// mul wants the low word, the mulh forms the high word
	assign result_o = (alu_op_i == OP_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
endmodule

//--- verilog/ex_alu.sv
`timescale 1ns/1ps
// integer datapath, multiply and divide result merge, operand bypass and branch compare
module ex_alu
	import ex_pkg::*;
(
	input  logic [XLEN-1:0]     src1_i,
	input  logic [XLEN-1:0]     src2_i,
	input  logic [ALU_OP_W-1:0] alu_op_i,
	input  logic [BR_OP_W-1:0]  br_op_i,
	input  logic [XLEN-1:0]     mul_result_i,    // from ex_mul
	input  logic [XLEN-1:0]     div_result_i,    // from ex_div, valid on done
	output logic [XLEN-1:0]     result_o,
	output logic                branch_o,        // instruction is a branch
	output logic                branch_taken_o   // condition met
);
	logic [SHAMT_W-1:0] shamt;
	logic               eq;
	logic               lt_s;
	logic               lt_u;

	assign shamt = src2_i[SHAMT_W-1:0];        // low bits only, as rv32
	assign eq    = (src1_i == src2_i);
	assign lt_s  = ($signed(src1_i) < $signed(src2_i));
	assign lt_u  = (src1_i < src2_i);

	always_comb
	begin
		case (alu_op_i)
			OP_ADD:    result_o = src1_i + src2_i;
			OP_SUB:    result_o = src1_i - src2_i;
			OP_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_s};
			OP_SLTU:   result_o = {{(XLEN-1){1'b0}}, lt_u};
			OP_AND:    result_o = src1_i & src2_i;
			OP_OR:     result_o = src1_i | src2_i;
			OP_XOR:    result_o = src1_i ^ src2_i;
			OP_SLL:    result_o = src1_i << shamt;
			OP_SRL:    result_o = src1_i >> shamt;
			OP_SRA:    result_o = $signed(src1_i) >>> shamt; // sign fill
			OP_MUL,
			OP_MULH,
			OP_MULHSU,
			OP_MULHU:  result_o = mul_result_i;
			OP_DIV,
			OP_DIVU,
			OP_REM,
			OP_REMU:   result_o = div_result_i;
			OP_PASS:   result_o = src2_i;                  // lui, jal link value
			default:   result_o = '0;
		endcase
	end

	assign branch_o = (br_op_i != BR_NONE);

	// conditions straight from the operands, no adder involved
	always_comb
	begin
		case (br_op_i)
			BR_EQ:   branch_taken_o = eq;
			BR_NE:   branch_taken_o = !eq;
			BR_LT:   branch_taken_o = lt_s;
			BR_GE:   branch_taken_o = !lt_s;
			BR_LTU:  branch_taken_o = lt_u;
			BR_GEU:  branch_taken_o = !lt_u;
			default: branch_taken_o = 1'b0;
		endcase
	end
endmodule

//--- verilog/ex_pkg.sv
// execute stage widths, operation codes, branch codes, size codes and divider states
package ex_pkg;
	localparam int XLEN      = 32;               // data and address width
	localparam int SHAMT_W   = 5;                // shift amount bits
	localparam int RD_W      = 6;                // rd index plus no-write bit
	localparam int ALU_OP_W  = 5;
	localparam int BR_OP_W   = 3;
	localparam int MEM_SIZE_W = 2;
	localparam int DIV_CNT_W = 6;                // counts 0..XLEN
	localparam int DIV_ST_W  = 2;

	localparam logic [RD_W-1:0] RD_NONE = 6'd32; // no register write

	localparam logic [ALU_OP_W-1:0] OP_ADD    = 5'd0;
	localparam logic [ALU_OP_W-1:0] OP_SUB    = 5'd1;
	localparam logic [ALU_OP_W-1:0] OP_SLT    = 5'd2;
	localparam logic [ALU_OP_W-1:0] OP_SLTU   = 5'd3;
	localparam logic [ALU_OP_W-1:0] OP_AND    = 5'd4;
	localparam logic [ALU_OP_W-1:0] OP_OR     = 5'd5;
	localparam logic [ALU_OP_W-1:0] OP_XOR    = 5'd6;
	localparam logic [ALU_OP_W-1:0] OP_SLL    = 5'd7;
	localparam logic [ALU_OP_W-1:0] OP_SRL    = 5'd8;
	localparam logic [ALU_OP_W-1:0] OP_SRA    = 5'd9;
	localparam logic [ALU_OP_W-1:0] OP_MUL    = 5'd10;
	localparam logic [ALU_OP_W-1:0] OP_MULH   = 5'd11;
	localparam logic [ALU_OP_W-1:0] OP_MULHSU = 5'd12;
	localparam logic [ALU_OP_W-1:0] OP_MULHU  = 5'd13;
	localparam logic [ALU_OP_W-1:0] OP_DIV    = 5'd14;
	localparam logic [ALU_OP_W-1:0] OP_DIVU   = 5'd15;
	localparam logic [ALU_OP_W-1:0] OP_REM    = 5'd16;
	localparam logic [ALU_OP_W-1:0] OP_REMU   = 5'd17;
	localparam logic [ALU_OP_W-1:0] OP_PASS   = 5'd18; // lui and jumps, result is src2

	localparam logic [BR_OP_W-1:0] BR_NONE = 3'd0;
	localparam logic [BR_OP_W-1:0] BR_EQ   = 3'd1;
	localparam logic [BR_OP_W-1:0] BR_NE   = 3'd2;
	localparam logic [BR_OP_W-1:0] BR_LT   = 3'd3;
	localparam logic [BR_OP_W-1:0] BR_GE   = 3'd4;
	localparam logic [BR_OP_W-1:0] BR_LTU  = 3'd5;
	localparam logic [BR_OP_W-1:0] BR_GEU  = 3'd6;

	localparam logic [MEM_SIZE_W-1:0] SIZE_B = 2'd0;
	localparam logic [MEM_SIZE_W-1:0] SIZE_H = 2'd1;
	localparam logic [MEM_SIZE_W-1:0] SIZE_W = 2'd2;

	localparam logic [DIV_ST_W-1:0] DIV_IDLE = 2'd0;
	localparam logic [DIV_ST_W-1:0] DIV_RUN  = 2'd1;
	localparam logic [DIV_ST_W-1:0] DIV_DONE = 2'd2;
endpackage
